/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_frontend
FLIST     ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FLIST)) $(wildcard verilog/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim.f */
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_redirect.sv
verilog/fetch_ctrl.sv
verilog/refill_counter.sv
verilog/icache.sv
verilog/inst_buffer.sv
verilog/frontend.sv
verif/tb_frontend.sv

/* verif/tb_frontend.sv */
`default_nettype none

`include "fetch_params.svh"

module tb_frontend;

  localparam int               NUM_ROWS = 16;
  localparam fetch_pkg::inst_t MEM_KEY  = 32'h1357_9bdf;
  localparam fetch_pkg::addr_t MTVEC    = 32'h0000_3048;
  localparam fetch_pkg::addr_t STVEC    = 32'h0000_2484;  // mid block
  localparam fetch_pkg::addr_t MEPC     = 32'h0000_1a68;
  localparam fetch_pkg::addr_t SEPC     = 32'h0000_2c94;
  localparam fetch_pkg::addr_t ANY_PC   = 32'h0000_5550;  // must never be fetched

  typedef struct packed {
    logic [7:0]         count;     // instructions to accept
    logic               redirect;
    logic               except_valid;
    fetch_pkg::except_t cause;
    fetch_pkg::addr_t   epc;
    fetch_pkg::addr_t   upd_pc;
    logic [31:0]        medeleg;
    logic [7:0]         stall;     // disp_ready pattern, zero means random
    fetch_pkg::addr_t   exp_pc;
  } row_t;

  logic                 i_clk;
  logic                 i_reset_n;
  fetch_pkg::commit_t   i_commit;
  fetch_pkg::csr_t      i_csr;
  fetch_pkg::mem_req_t  o_mem_req;
  fetch_pkg::mem_resp_t i_mem_resp;
  fetch_pkg::disp_t     o_disp;
  logic                 i_disp_ready;

  row_t                 rows [NUM_ROWS];
  logic                 table_ready = 1'b0;
  fetch_pkg::addr_t     next_pc;
  fetch_pkg::addr_t     line_tag  [`FETCH_IC_SETS];
  logic                 line_held [`FETCH_IC_SETS];
  logic                 refill_open;
  fetch_pkg::addr_t     refill_line;
  int unsigned          beat_num;
  int unsigned          beat_wait;
  logic                 held_valid;
  fetch_pkg::disp_t     held_disp;
  logic                 last_commit;

  initial i_clk = 1'b0;
  always #2 i_clk = ~i_clk;

  frontend frontend_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_commit     (i_commit),
    .i_csr        (i_csr),
    .o_mem_req    (o_mem_req),
    .i_mem_resp   (i_mem_resp),
    .o_disp       (o_disp),
    .i_disp_ready (i_disp_ready)
  );

  // ============================================================
  // stimulus table
  // ============================================================
  task automatic load_table();
    rows[0]  = '{8'd12, '0, '0, fetch_pkg::INST_ADDR_MISALIGN, ANY_PC, ANY_PC, 32'h0, 8'hff,
                 `FETCH_PC_INIT};
    rows[1]  = '{8'd8, '1, '0, fetch_pkg::INST_ADDR_MISALIGN, ANY_PC, 32'h0000_1044, 32'h0,
                 8'h6d, 32'h0000_1044};
    rows[2]  = '{8'd4, '1, '1, fetch_pkg::INST_ADDR_MISALIGN, ANY_PC, ANY_PC, 32'h1, 8'hb5, STVEC};
    rows[3]  = '{8'd4, '1, '1, fetch_pkg::INST_ADDR_MISALIGN, ANY_PC, ANY_PC, 32'hffff_fffe, 8'h00,
                 MTVEC};
    rows[4]  = '{8'd4, '1, '1, fetch_pkg::INST_ACC_FAULT, ANY_PC, ANY_PC, 32'h2, 8'h93, STVEC};
    rows[5]  = '{8'd4, '1, '1, fetch_pkg::INST_ACC_FAULT, ANY_PC, ANY_PC, 32'hffff_fffd, 8'hf1,
                 MTVEC};
    rows[6]  = '{8'd4, '1, '1, fetch_pkg::ECALL_U, ANY_PC, ANY_PC, 32'h100, 8'h5a, STVEC};
    rows[7]  = '{8'd4, '1, '1, fetch_pkg::ECALL_U, ANY_PC, ANY_PC, 32'hffff_feff, 8'h00, MTVEC};
    rows[8]  = '{8'd4, '1, '1, fetch_pkg::ECALL_S, ANY_PC, ANY_PC, 32'h200, 8'hc3, STVEC};
    rows[9]  = '{8'd4, '1, '1, fetch_pkg::ECALL_S, ANY_PC, ANY_PC, 32'hffff_fdff, 8'h2f, MTVEC};
    rows[10] = '{8'd4, '1, '1, fetch_pkg::ECALL_M, ANY_PC, ANY_PC, 32'h800, 8'h81, STVEC};
    rows[11] = '{8'd4, '1, '1, fetch_pkg::ECALL_M, ANY_PC, ANY_PC, 32'hffff_f7ff, 8'h00, MTVEC};
    rows[12] = '{8'd4, '1, '1, fetch_pkg::MRET, ANY_PC, ANY_PC, 32'hffff_ffff, 8'hee, MEPC};
    rows[13] = '{8'd4, '1, '1, fetch_pkg::SRET, ANY_PC, ANY_PC, 32'h0, 8'h00, SEPC};
    rows[14] = '{8'd4, '1, '1, fetch_pkg::SILENT_FLUSH, 32'h0000_1f4c, ANY_PC, 32'h0, 8'h77,
                 32'h0000_1f50};
    // back to the reset loop, its lines are still in the cache
    rows[15] = '{8'd6, '1, '0, fetch_pkg::INST_ADDR_MISALIGN, ANY_PC, 32'h0000_1000, 32'h0,
                 8'h00, 32'h0000_1000};
    table_ready = 1'b1;
  endtask

  function automatic fetch_pkg::inst_t mem_word(input fetch_pkg::addr_t addr);
    return addr ^ MEM_KEY;
  endfunction

  function automatic int unsigned set_of(input fetch_pkg::addr_t addr);
    return (addr / `FETCH_LINE_BYTES) % `FETCH_IC_SETS;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  // ============================================================
  // compare tasks
  // ============================================================
  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] t=%0t %s: got %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input fetch_pkg::addr_t got,
                            input fetch_pkg::addr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_inst(input string name, input fetch_pkg::inst_t got,
                            input fetch_pkg::inst_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_mem_req(input fetch_pkg::mem_req_t req);
    fetch_pkg::addr_t aligned;
    int unsigned      idx;
    aligned = req.addr & ~fetch_pkg::addr_t'(`FETCH_LINE_BYTES - 1);
    idx     = set_of(req.addr);
    check_addr("o_mem_req.addr", req.addr, aligned);
    if (refill_open) begin
      abort_run("a memory request arrived while a line refill was still open");
    end
    if (line_held[idx] && line_tag[idx] == req.addr) begin
      abort_run($sformatf("line %h was requested again while it is still in the cache",
                          req.addr));
    end
    line_held[idx] = 1'b1;  // direct mapped, the new line replaces the old one
    line_tag[idx]  = req.addr;
  endtask

  // ============================================================
  // memory model and per-cycle sampling
  // ============================================================
  task automatic drive_memory();
    i_mem_resp = '0;
    if (refill_open) begin
      if (beat_wait == 0) begin
        i_mem_resp.valid = 1'b1;
        i_mem_resp.data  = mem_word(refill_line + fetch_pkg::addr_t'(beat_num * 4));
        beat_num++;
        beat_wait = $urandom % 6;
        if (beat_num == `FETCH_LINE_BYTES / 4) begin
          refill_open = 1'b0;
        end
      end else begin
        beat_wait--;
      end
    end
  endtask

  task automatic watch_memory();
    if (o_mem_req.valid === 1'b1) begin
      check_mem_req(o_mem_req);
      refill_open = 1'b1;
      refill_line = o_mem_req.addr;
      beat_num    = 0;
      beat_wait   = $urandom % 6;
    end
  endtask

  task automatic watch_dispatch(input logic redirected, output logic took);
    took = 1'b0;
    if (held_valid && !redirected) begin
      check_flag("o_disp.valid (stalled)", o_disp.valid, 1'b1);
      check_addr("o_disp.pc (stalled)", o_disp.pc, held_disp.pc);
      check_inst("o_disp.inst (stalled)", o_disp.inst, held_disp.inst);
    end
    held_valid = (o_disp.valid === 1'b1) && !i_disp_ready;
    held_disp  = o_disp;
    if (o_disp.valid === 1'b1 && i_disp_ready) begin
      check_addr("o_disp.pc", o_disp.pc, next_pc);
      check_inst("o_disp.inst", o_disp.inst, mem_word(next_pc));
      next_pc = next_pc + fetch_pkg::addr_t'(4);
      took    = 1'b1;
    end
  endtask

  task automatic run_cycle(input fetch_pkg::csr_t csr, input fetch_pkg::commit_t commit,
                           input logic ready, output logic took);
    @(negedge i_clk);
    i_csr        = csr;
    i_commit     = commit;
    i_disp_ready = ready;
    drive_memory();
    #1;
    watch_memory();
    if (commit.valid || last_commit) begin
      check_flag("o_disp.valid (after redirect)", o_disp.valid, 1'b0);  // old blocks dropped
    end
    last_commit = commit.valid;
    watch_dispatch(commit.valid, took);
  endtask

  initial begin : main
    fetch_pkg::commit_t commit;
    fetch_pkg::csr_t    csr;
    logic               took;
    logic               ready;
    int unsigned        taken;
    int unsigned        cyc;
    void'($urandom(49));
    i_reset_n    = 1'b0;
    i_commit     = '0;
    i_mem_resp   = '0;
    i_disp_ready = 1'b0;
    csr          = '{mtvec: MTVEC, stvec: STVEC, mepc: MEPC, sepc: SEPC, medeleg: '0};
    i_csr        = csr;
    refill_open  = 1'b0;
    held_valid   = 1'b0;
    last_commit  = 1'b0;
    for (int s = 0; s < `FETCH_IC_SETS; s++) begin
      line_held[s] = 1'b0;
    end
    load_table();
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    #1;
    check_flag("o_disp.valid", o_disp.valid, 1'b0);
    check_flag("o_mem_req.valid", o_mem_req.valid, 1'b0);

    for (int r = 0; r < NUM_ROWS; r++) begin
      next_pc = rows[r].exp_pc;
      if (rows[r].redirect) begin
        commit              = '0;
        commit.valid        = 1'b1;
        commit.except_valid = rows[r].except_valid;
        commit.except_type  = rows[r].cause;
        commit.epc          = rows[r].epc;
        commit.upd_pc       = rows[r].upd_pc;
        csr.medeleg         = rows[r].medeleg;
        run_cycle(csr, commit, 1'b0, took);
      end
      commit = '0;
      taken  = 0;
      cyc    = 0;
      while (taken < rows[r].count) begin
        if (rows[r].stall == 8'h00) begin
          ready = ($urandom % 2) == 1;
        end else begin
          ready = rows[r].stall[cyc[2:0]];
        end
        run_cycle(csr, commit, ready, took);
        cyc++;
        if (took) begin
          taken++;
        end
      end
    end

    $display("TESTS PASSED");
    $finish;
  end

  initial begin : watchdog
    int unsigned limit;
    wait (table_ready);
    limit = 20;  // reset and start up
    for (int r = 0; r < NUM_ROWS; r++) begin
      limit += rows[r].count * 40;
    end
    repeat (limit) @(posedge i_clk);
    abort_run($sformatf("timeout after %0d cycles, dispatch stopped making progress", limit));
  end

endmodule

`default_nettype wire

/* verilog/fetch_ctrl.sv */
`default_nettype none

`include "fetch_params.svh"

module fetch_ctrl (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_redirect_valid,
  input  fetch_pkg::addr_t    i_redirect_pc,
  output fetch_pkg::ic_req_t  o_ic_req,
  input  logic                i_ic_ready,
  input  fetch_pkg::ic_resp_t i_ic_resp,
  output logic                o_ibuf_load,
  input  logic                i_ibuf_ready
);

  localparam fetch_pkg::addr_t BLK_MASK = fetch_pkg::addr_t'(`FETCH_BLOCK_BYTES - 1);

  fetch_pkg::if_state_t r_state;
  fetch_pkg::if_state_t w_state_next;
  fetch_pkg::addr_t     r_pc;
  fetch_pkg::addr_t     w_pc_next;
  fetch_pkg::addr_t     w_req_pc;
  fetch_pkg::addr_t     w_req_pc_inc;
  fetch_pkg::addr_t     w_resp_pc;
  logic                 w_req_valid;
  logic                 w_accept;
  logic                 w_resp_hit;
  logic                 w_resp_miss;
  logic                 w_resp_refused;

  assign w_resp_hit     = i_ic_resp.valid & ~i_ic_resp.miss;
  assign w_resp_miss    = i_ic_resp.valid & i_ic_resp.miss;
  assign w_resp_refused = w_resp_hit & ~i_ibuf_ready;

  // lower slot masked off means the block was entered mid way
  assign w_resp_pc = i_ic_resp.addr | (i_ic_resp.mask[0] ? '0 : fetch_pkg::addr_t'(4));

  assign w_req_pc     = i_redirect_valid ? i_redirect_pc : r_pc;
  assign w_req_pc_inc = (w_req_pc & ~BLK_MASK) + fetch_pkg::addr_t'(`FETCH_BLOCK_BYTES);

  always_comb begin
    case (r_state)
      fetch_pkg::ISSUED       : w_req_valid = ~(w_resp_miss | w_resp_refused);
      fetch_pkg::WAIT_IC_FILL : w_req_valid = 1'b1;
      fetch_pkg::WAIT_FB_FREE : w_req_valid = i_ibuf_ready;
      default                 : w_req_valid = 1'b0;
    endcase
    if (i_redirect_valid) begin
      w_req_valid = 1'b1;
    end
  end

  assign w_accept       = w_req_valid & i_ic_ready;
  assign o_ic_req.valid = w_accept;
  assign o_ic_req.addr  = w_req_pc;
  assign o_ibuf_load    = (r_state == fetch_pkg::ISSUED) & w_resp_hit & i_ibuf_ready;

  always_comb begin
    w_state_next = r_state;
    w_pc_next    = r_pc;
    if (i_redirect_valid) begin
      w_state_next = w_accept ? fetch_pkg::ISSUED : fetch_pkg::WAIT_IC_FILL;
      w_pc_next    = w_accept ? w_req_pc_inc : i_redirect_pc;
    end else begin
      case (r_state)
        fetch_pkg::INIT : w_state_next = fetch_pkg::ISSUED;
        fetch_pkg::ISSUED : begin
          if (w_resp_miss) begin
            w_state_next = fetch_pkg::WAIT_IC_FILL;
            w_pc_next    = w_resp_pc;
          end else if (w_resp_refused) begin
            w_state_next = fetch_pkg::WAIT_FB_FREE;
            w_pc_next    = w_resp_pc;   // fetch the refused block again
          end else if (w_accept) begin
            w_pc_next = w_req_pc_inc;
          end
        end
        fetch_pkg::WAIT_IC_FILL,
        fetch_pkg::WAIT_FB_FREE : begin
          if (w_accept) begin
            w_state_next = fetch_pkg::ISSUED;
            w_pc_next    = w_req_pc_inc;
          end
        end
        default : w_state_next = fetch_pkg::INIT;
      endcase
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= fetch_pkg::INIT;
      r_pc    <= `FETCH_PC_INIT;
    end else begin
      r_state <= w_state_next;
      r_pc    <= w_pc_next;
    end
  end

  a_state_legal : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !$isunknown(r_state) && r_state inside {fetch_pkg::INIT, fetch_pkg::ISSUED,
                                            fetch_pkg::WAIT_IC_FILL, fetch_pkg::WAIT_FB_FREE});

endmodule

`default_nettype wire

/* verilog/fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// ============================================================
// datapath widths and reset vector
// ============================================================
`define FETCH_XLEN          32
`define FETCH_PC_INIT       32'h0000_1000

// ============================================================
// fetch block, cache geometry and buffer
// ============================================================
`define FETCH_BLOCK_BYTES   8   // two instructions
`define FETCH_LINE_BYTES    16  // four refill beats
`define FETCH_IC_SETS       16
`define FETCH_IBUF_DEPTH    4   // in fetch blocks

`endif

/* verilog/fetch_pkg.sv */
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

  typedef logic [`FETCH_XLEN-1:0]                  addr_t;
  typedef logic [31:0]                             inst_t;
  typedef logic [`FETCH_BLOCK_BYTES*8-1:0]         block_t;
  typedef logic [`FETCH_BLOCK_BYTES/4-1:0]         slot_mask_t;
  typedef logic [$clog2(`FETCH_LINE_BYTES/4)-1:0]  beat_idx_t;

  // mcause numbering, the last three sit in unused codes
  typedef enum logic [4:0] {
    INST_ADDR_MISALIGN = 5'd0,
    INST_ACC_FAULT     = 5'd1,
    ECALL_U            = 5'd8,
    ECALL_S            = 5'd9,
    ECALL_M            = 5'd11,
    SILENT_FLUSH       = 5'd16,
    MRET               = 5'd17,
    SRET               = 5'd18
  } except_t;

  typedef enum logic [2:0] {
    INIT         = 3'd0,
    ISSUED       = 3'd1,
    WAIT_IC_FILL = 3'd3,
    WAIT_FB_FREE = 3'd4
  } if_state_t;

  typedef struct packed {
    logic    valid;
    logic    except_valid;
    except_t except_type;
    addr_t   epc;
    addr_t   upd_pc;
  } commit_t;

  typedef struct packed {
    addr_t                  mtvec;
    addr_t                  stvec;
    addr_t                  mepc;
    addr_t                  sepc;
    logic [`FETCH_XLEN-1:0] medeleg;
  } csr_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } ic_req_t;

  typedef struct packed {
    logic       valid;
    logic       miss;
    addr_t      addr;   // block aligned
    block_t     data;
    slot_mask_t mask;
  } ic_resp_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;        // line aligned
  } mem_req_t;

  typedef struct packed {
    logic                   valid;
    logic [`FETCH_XLEN-1:0] data;
  } mem_resp_t;

  typedef struct packed {
    logic  valid;
    addr_t pc;
    inst_t inst;
  } disp_t;

endpackage

`default_nettype wire

/* verilog/fetch_redirect.sv */
`default_nettype none

module fetch_redirect (
  input  fetch_pkg::commit_t i_commit,
  input  fetch_pkg::csr_t    i_csr,
  output logic               o_redirect_valid,
  output fetch_pkg::addr_t   o_redirect_pc
);

  logic w_deleg;

  assign o_redirect_valid = i_commit.valid;
  assign w_deleg          = i_csr.medeleg[i_commit.except_type];

  always_comb begin
    if (i_commit.except_valid) begin
      case (i_commit.except_type)
        fetch_pkg::SILENT_FLUSH : o_redirect_pc = i_commit.epc + fetch_pkg::addr_t'(4);
        fetch_pkg::MRET         : o_redirect_pc = i_csr.mepc;
        fetch_pkg::SRET         : o_redirect_pc = i_csr.sepc;
        fetch_pkg::INST_ADDR_MISALIGN,
        fetch_pkg::INST_ACC_FAULT,
        fetch_pkg::ECALL_U,
        fetch_pkg::ECALL_S,
        fetch_pkg::ECALL_M : begin
          // delegated traps land in supervisor mode
          o_redirect_pc = w_deleg ? i_csr.stvec : i_csr.mtvec;
        end
        default : o_redirect_pc = i_csr.mtvec;
      endcase
    end else begin
      o_redirect_pc = i_commit.upd_pc;  // plain pc update
    end
  end

  // committer only sends the causes this front end knows
  always_comb begin
    if (i_commit.valid && i_commit.except_valid) begin
      a_known_cause : assert (i_commit.except_type inside {
                                fetch_pkg::INST_ADDR_MISALIGN, fetch_pkg::INST_ACC_FAULT,
                                fetch_pkg::ECALL_U, fetch_pkg::ECALL_S, fetch_pkg::ECALL_M,
                                fetch_pkg::SILENT_FLUSH, fetch_pkg::MRET, fetch_pkg::SRET})
        else $error("unsupported commit cause %0d", i_commit.except_type);
    end
  end

endmodule

`default_nettype wire

/* verilog/frontend.sv */
`default_nettype none

module frontend (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  fetch_pkg::commit_t   i_commit,
  input  fetch_pkg::csr_t      i_csr,
  output fetch_pkg::mem_req_t  o_mem_req,
  input  fetch_pkg::mem_resp_t i_mem_resp,
  output fetch_pkg::disp_t     o_disp,
  input  logic                 i_disp_ready
);

  logic                 w_redirect_valid;
  fetch_pkg::addr_t     w_redirect_pc;
  fetch_pkg::ic_req_t   w_ic_req;
  logic                 w_ic_ready;
  fetch_pkg::ic_resp_t  w_ic_resp;
  logic                 w_ibuf_load;
  logic                 w_ibuf_ready;
  logic                 w_fill_start;
  logic                 w_fill_done;
  fetch_pkg::beat_idx_t w_beat_idx;

  // ============================================================
  // next pc and fetch control
  // ============================================================
  fetch_redirect u_fetch_redirect (
    .i_commit         (i_commit),
    .i_csr            (i_csr),
    .o_redirect_valid (w_redirect_valid),
    .o_redirect_pc    (w_redirect_pc)
  );

  fetch_ctrl u_fetch_ctrl (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_redirect_valid (w_redirect_valid),
    .i_redirect_pc    (w_redirect_pc),
    .o_ic_req         (w_ic_req),
    .i_ic_ready       (w_ic_ready),
    .i_ic_resp        (w_ic_resp),
    .o_ibuf_load      (w_ibuf_load),
    .i_ibuf_ready     (w_ibuf_ready)
  );

  // ============================================================
  // cache and refill
  // ============================================================
  icache u_icache (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_flush      (w_redirect_valid),
    .i_req        (w_ic_req),
    .o_ready      (w_ic_ready),
    .o_resp       (w_ic_resp),
    .o_mem_req    (o_mem_req),
    .i_mem_data   (i_mem_resp),
    .o_fill_start (w_fill_start),
    .i_beat_idx   (w_beat_idx),
    .i_fill_done  (w_fill_done)
  );

  refill_counter u_refill_counter (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_fill_start (w_fill_start),
    .i_beat_valid (i_mem_resp.valid),
    .o_beat_idx   (w_beat_idx),
    .o_fill_done  (w_fill_done),
    .o_busy       ()              // cache keeps its own fill flag
  );

  // ============================================================
  // dispatch side
  // ============================================================
  inst_buffer u_inst_buffer (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_clear      (w_redirect_valid),
    .i_load       (w_ibuf_load),
    .i_block      (w_ic_resp),
    .o_ready      (w_ibuf_ready),
    .o_disp       (o_disp),
    .i_disp_ready (i_disp_ready)
  );

endmodule

`default_nettype wire

/* verilog/icache.sv */
`default_nettype none

`include "fetch_params.svh"

module icache (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_flush,
  input  fetch_pkg::ic_req_t   i_req,
  output logic                 o_ready,
  output fetch_pkg::ic_resp_t  o_resp,
  output fetch_pkg::mem_req_t  o_mem_req,
  input  fetch_pkg::mem_resp_t i_mem_data,
  output logic                 o_fill_start,
  input  fetch_pkg::beat_idx_t i_beat_idx,
  input  logic                 i_fill_done
);

  localparam int SETS      = `FETCH_IC_SETS;
  localparam int IDX_W     = $clog2(SETS);
  localparam int LINE_OFF  = $clog2(`FETCH_LINE_BYTES);
  localparam int BLK_OFF   = $clog2(`FETCH_BLOCK_BYTES);
  localparam int TAG_W     = `FETCH_XLEN - LINE_OFF - IDX_W;
  localparam int LINE_BITS = `FETCH_LINE_BYTES * 8;
  localparam int BLK_BITS  = `FETCH_BLOCK_BYTES * 8;
  localparam int SLOTS     = `FETCH_BLOCK_BYTES / 4;

  // ============================================================
  // arrays
  // ============================================================
  logic [SETS-1:0]      r_line_valid;
  logic [TAG_W-1:0]     r_tag  [SETS];
  logic [LINE_BITS-1:0] r_data [SETS];

  logic                 r_lkup_valid;
  fetch_pkg::addr_t     r_lkup_addr;
  logic [IDX_W-1:0]     w_lkup_idx;
  logic [TAG_W-1:0]     w_lkup_tag;
  logic                 w_hit;
  logic                 w_miss;

  logic                 r_fill_busy;
  logic                 r_mem_req;
  fetch_pkg::addr_t     r_fill_addr;
  logic [IDX_W-1:0]     w_fill_idx;

  // ============================================================
  // lookup, one cycle behind the request
  // ============================================================
  assign o_ready = ~r_fill_busy;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_lkup_valid <= 1'b0;
    end else begin
      r_lkup_valid <= i_req.valid & o_ready;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_req.valid && o_ready) begin
      r_lkup_addr <= i_req.addr;
    end
  end

  assign w_lkup_idx = r_lkup_addr[LINE_OFF +: IDX_W];
  assign w_lkup_tag = r_lkup_addr[LINE_OFF+IDX_W +: TAG_W];
  assign w_hit      = r_line_valid[w_lkup_idx] & (r_tag[w_lkup_idx] == w_lkup_tag);
  assign w_miss     = r_lkup_valid & ~w_hit & ~i_flush;

  assign o_resp.valid = r_lkup_valid & ~i_flush;  // redirect kills it
  assign o_resp.miss  = ~w_hit;
  assign o_resp.addr  = r_lkup_addr & ~fetch_pkg::addr_t'(`FETCH_BLOCK_BYTES - 1);
  assign o_resp.data  = r_data[w_lkup_idx][r_lkup_addr[LINE_OFF-1:BLK_OFF]*BLK_BITS +: BLK_BITS];
  assign o_resp.mask  = {SLOTS{1'b1}} << r_lkup_addr[BLK_OFF-1:2];

  // ============================================================
  // refill
  // ============================================================
  assign w_fill_idx      = r_fill_addr[LINE_OFF +: IDX_W];
  assign o_fill_start    = w_miss;
  assign o_mem_req.valid = r_mem_req;
  assign o_mem_req.addr  = r_fill_addr;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_fill_busy  <= 1'b0;
      r_mem_req    <= 1'b0;
      r_line_valid <= '0;
    end else begin
      r_mem_req <= w_miss;  // strobe one cycle after the miss
      if (w_miss) begin
        r_fill_busy <= 1'b1;
      end else if (i_fill_done) begin
        r_fill_busy <= 1'b0;
      end
      if (i_fill_done) begin
        r_line_valid[w_fill_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_miss) begin
      r_fill_addr <= r_lkup_addr & ~fetch_pkg::addr_t'(`FETCH_LINE_BYTES - 1);
    end
    if (i_mem_data.valid && r_fill_busy) begin
      r_data[w_fill_idx][i_beat_idx*32 +: 32] <= i_mem_data.data;
    end
    if (i_fill_done) begin
      r_tag[w_fill_idx] <= r_fill_addr[LINE_OFF+IDX_W +: TAG_W];
    end
  end

endmodule

`default_nettype wire

/* verilog/inst_buffer.sv */
`default_nettype none

`include "fetch_params.svh"

module inst_buffer (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_clear,
  input  logic                i_load,
  input  fetch_pkg::ic_resp_t i_block,
  output logic                o_ready,
  output fetch_pkg::disp_t    o_disp,
  input  logic                i_disp_ready
);

  localparam int DEPTH  = `FETCH_IBUF_DEPTH;
  localparam int PTR_W  = $clog2(DEPTH);
  localparam int SLOTS  = `FETCH_BLOCK_BYTES / 4;
  localparam int SLOT_W = $clog2(SLOTS);

  fetch_pkg::addr_t      r_addr [DEPTH];
  fetch_pkg::block_t     r_data [DEPTH];
  fetch_pkg::slot_mask_t r_mask [DEPTH];  // slots still to dispatch
  logic [PTR_W-1:0]      r_rptr;
  logic [PTR_W-1:0]      r_wptr;
  logic [PTR_W:0]        r_count;

  fetch_pkg::slot_mask_t w_head_mask;
  fetch_pkg::slot_mask_t w_mask_left;
  logic [SLOT_W-1:0]     w_slot;
  logic                  w_take;
  logic                  w_pop;

  assign w_head_mask = r_mask[r_rptr];

  // lowest pending slot goes first
  always_comb begin
    w_slot = '0;
    for (int i = SLOTS - 1; i >= 0; i--) begin
      if (w_head_mask[i]) begin
        w_slot = SLOT_W'(i);
      end
    end
  end

  assign w_mask_left = w_head_mask & ~(fetch_pkg::slot_mask_t'(1) << w_slot);
  assign w_take      = o_disp.valid & i_disp_ready;
  assign w_pop       = w_take & (w_mask_left == '0);

  assign o_ready     = r_count != (PTR_W+1)'(DEPTH);
  assign o_disp.valid = (r_count != '0) & ~i_clear;
  assign o_disp.pc    = r_addr[r_rptr] + fetch_pkg::addr_t'({w_slot, 2'b00});
  assign o_disp.inst  = r_data[r_rptr][w_slot*32 +: 32];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rptr  <= '0;
      r_wptr  <= '0;
      r_count <= '0;
    end else if (i_clear) begin
      r_rptr  <= '0;
      r_wptr  <= '0;
      r_count <= '0;
    end else begin
      if (i_load) begin
        r_wptr <= r_wptr + 1'b1;
      end
      if (w_pop) begin
        r_rptr <= r_rptr + 1'b1;
      end
      r_count <= r_count + (PTR_W+1)'(i_load) - (PTR_W+1)'(w_pop);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_addr[r_wptr] <= i_block.addr;
      r_data[r_wptr] <= i_block.data;
      r_mask[r_wptr] <= i_block.mask;
    end
    if (w_take && !w_pop) begin
      r_mask[r_rptr] <= w_mask_left;
    end
  end

  // fetch side loads only hit blocks, and only into free room
  a_load_room : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_load |-> o_ready && i_block.valid && !i_block.miss);

endmodule

`default_nettype wire

/* verilog/refill_counter.sv */
`default_nettype none

module refill_counter (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_fill_start,
  input  logic                 i_beat_valid,
  output fetch_pkg::beat_idx_t o_beat_idx,
  output logic                 o_fill_done,
  output logic                 o_busy
);

  fetch_pkg::beat_idx_t r_idx;
  logic                 r_busy;
  logic                 w_last;

  assign w_last      = r_idx == '1;
  assign o_beat_idx  = r_idx;
  assign o_busy      = r_busy;
  assign o_fill_done = r_busy & i_beat_valid & w_last;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_busy <= 1'b0;
      r_idx  <= '0;
    end else if (i_fill_start) begin
      r_busy <= 1'b1;
      r_idx  <= '0;
    end else if (r_busy && i_beat_valid) begin
      r_idx <= r_idx + 1'b1;  // wraps to zero after the last beat
      if (w_last) begin
        r_busy <= 1'b0;
      end
    end
  end

  // cache must not open a second miss before the line is complete
  a_no_start_busy : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_fill_start |-> !r_busy);

endmodule

`default_nettype wire
